/* source/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    // switch geometry
    localparam int unsigned NUM_PORTS   = 4;
    localparam int unsigned PORT_W      = 2;

    // buffer pointer width into the shared frame memory
    localparam int unsigned ADDR_W      = 8;

    // per output port pointer queue
    localparam int unsigned VOQ_DEPTH   = 4;
    localparam int unsigned VOQ_IDX_W   = $clog2(VOQ_DEPTH);
    localparam int unsigned VOQ_CNT_W   = $clog2(VOQ_DEPTH + 1);

    // direct mapped address table, low mac bits pick the entry
    localparam int unsigned TABLE_IDX_W = 4;
    localparam int unsigned TABLE_DEPTH = 1 << TABLE_IDX_W;

    // mac kept as two 24 bit words, word 0 holds the low bits
    localparam int unsigned MAC_WORD_W  = 24;
    localparam logic [47:0] BCAST_MAC   = 48'hffff_ffff_ffff;

    typedef logic [1:0][MAC_WORD_W-1:0] mac_t;
    typedef logic [PORT_W-1:0]          port_t;
    typedef logic [ADDR_W-1:0]          ptr_t;
    typedef logic [NUM_PORTS-1:0]       port_mask_t;

    // forwarding decision of the translator
    typedef enum logic [1:0] {
        FWD_UNICAST = 2'd0,
        FWD_FLOOD   = 2'd1,
        FWD_FILTER  = 2'd2
    } fwd_e;

endpackage

`default_nettype wire

/* source/switch_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// one end-of-frame descriptor per cycle, arbiter to translator
interface desc_if;
    import switch_pkg::*;

    // strobe, fields only meaningful with it
    logic  valid;
    port_t port;
    mac_t  src_mac;
    mac_t  dst_mac;
    ptr_t  start_ptr;

    modport src (output valid, port, src_mac, dst_mac, start_ptr);
    modport dst (input valid, port, src_mac, dst_mac, start_ptr);
endinterface

// translator to address table, read and learn side
interface lookup_if;
    import switch_pkg::*;

    // read side, answer one cycle later
    logic  read_req;
    mac_t  read_mac;
    logic  hit;
    port_t read_port;

    // learn side, written on the clock edge
    logic  learn_req;
    mac_t  learn_mac;
    port_t learn_port;

    modport requester (
        output read_req, read_mac, learn_req, learn_mac, learn_port,
        input  hit, read_port
    );
    modport tbl (
        input  read_req, read_mac, learn_req, learn_mac, learn_port,
        output hit, read_port
    );
endinterface

`default_nettype wire

/* source/desc_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_arbiter (
    input  logic                                switch_clk,
    input  logic                                arst_n_i,
    input  logic [switch_pkg::NUM_PORTS-1:0]    frame_eof_i,
    input  switch_pkg::mac_t                    src_mac_i   [switch_pkg::NUM_PORTS-1:0],
    input  switch_pkg::mac_t                    dst_mac_i   [switch_pkg::NUM_PORTS-1:0],
    input  switch_pkg::ptr_t                    start_ptr_i [switch_pkg::NUM_PORTS-1:0],
    desc_if.src                                 desc_o
);
    import switch_pkg::*;

    // pending flag and held payload per ingress port
    port_mask_t pending_q;
    mac_t       src_q [NUM_PORTS-1:0];
    mac_t       dst_q [NUM_PORTS-1:0];
    ptr_t       ptr_q [NUM_PORTS-1:0];

    // round robin state
    port_t      rr_ptr_q;
    port_mask_t grant;
    port_t      grant_port;
    port_t      scan_port;
    logic       found;

    // capture descriptor fields on the strobe
    always_ff @(posedge switch_clk) begin
        for (int unsigned p = 0; p < NUM_PORTS; p++) begin
            if (frame_eof_i[p]) begin
                src_q[p] <= src_mac_i[p];
                dst_q[p] <= dst_mac_i[p];
                ptr_q[p] <= start_ptr_i[p];
            end
        end
    end

    // first pending port at or after rr pointer
    always_comb begin
        grant      = '0;
        grant_port = rr_ptr_q;
        scan_port  = rr_ptr_q;
        found      = 1'b0;
        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            scan_port = PORT_W'((32'(rr_ptr_q) + i) % NUM_PORTS);
            if (!found && pending_q[scan_port]) begin
                found             = 1'b1;
                grant[scan_port]  = 1'b1;
                grant_port        = scan_port;
            end
        end
    end

    // pending set by strobe and cleared by grant
    always_ff @(posedge switch_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            rr_ptr_q     <= '0;
            desc_o.valid <= 1'b0;
        end else begin
            pending_q    <= frame_eof_i | (pending_q & ~grant);
            desc_o.valid <= found;
            // pointer moves past the served port
            if (found) begin
                rr_ptr_q <= PORT_W'((32'(grant_port) + 1) % NUM_PORTS);
            end
        end
    end

    // registered descriptor fields
    always_ff @(posedge switch_clk) begin
        if (found) begin
            desc_o.port      <= grant_port;
            desc_o.src_mac   <= src_q[grant_port];
            desc_o.dst_mac   <= dst_q[grant_port];
            desc_o.start_ptr <= ptr_q[grant_port];
        end
    end

    // ingress must not report a new frame before the old one is served
    a_eof_while_pending: assert property (
        @(posedge switch_clk) disable iff (!arst_n_i)
        (frame_eof_i & pending_q) == '0
    ) else $error("eof strobe on a port with a pending descriptor");

    // at most one pending flag is served per cycle
    a_one_grant: assert property (
        @(posedge switch_clk) disable iff (!arst_n_i)
        $onehot0($past(pending_q) & ~pending_q)
    ) else $error("more than one port granted");

endmodule

`default_nettype wire

/* source/address_table.sv */
`timescale 1ns/1ps
`default_nettype none

module address_table (
    input  logic    switch_clk,
    input  logic    arst_n_i,
    lookup_if.tbl   lookup_i
);
    import switch_pkg::*;

    // stored entries, each with its own valid bit
    mac_t                   entry_mac  [TABLE_DEPTH-1:0];
    port_t                  entry_port [TABLE_DEPTH-1:0];
    logic [TABLE_DEPTH-1:0] entry_valid_q;

    logic [TABLE_IDX_W-1:0] rd_idx;
    logic [TABLE_IDX_W-1:0] wr_idx;
    logic                   bypass;
    logic                   rd_hit;
    port_t                  rd_port;

    // low mac bits index the table
    assign rd_idx = lookup_i.read_mac[0][TABLE_IDX_W-1:0];
    assign wr_idx = lookup_i.learn_mac[0][TABLE_IDX_W-1:0];

    // learn to the read index this cycle wins over the stored entry
    assign bypass = lookup_i.learn_req && (wr_idx == rd_idx);

    always_comb begin
        if (bypass) begin
            // learned mac may have evicted the one being looked up
            rd_hit  = (lookup_i.learn_mac == lookup_i.read_mac);
            rd_port = lookup_i.learn_port;
        end else begin
            rd_hit  = entry_valid_q[rd_idx] && (entry_mac[rd_idx] == lookup_i.read_mac);
            rd_port = entry_port[rd_idx];
        end
    end

    // learn overwrites the whole entry
    always_ff @(posedge switch_clk) begin
        if (lookup_i.learn_req) begin
            entry_mac[wr_idx]  <= lookup_i.learn_mac;
            entry_port[wr_idx] <= lookup_i.learn_port;
        end
    end

    always_ff @(posedge switch_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entry_valid_q <= '0;
            lookup_i.hit  <= 1'b0;
        end else begin
            if (lookup_i.learn_req) begin
                entry_valid_q[wr_idx] <= 1'b1;
            end
            // hit only answers a request
            lookup_i.hit <= lookup_i.read_req && rd_hit;
        end
    end

    // port answer is only meaningful with hit
    always_ff @(posedge switch_clk) begin
        if (lookup_i.read_req) begin
            lookup_i.read_port <= rd_port;
        end
    end

    // each learn follows its own lookup by one cycle and names a real port
    a_learn_port_range: assert property (
        @(posedge switch_clk) disable iff (!arst_n_i)
        lookup_i.learn_req |-> $past(lookup_i.read_req)
            && (32'(lookup_i.learn_port) < NUM_PORTS)
    ) else $error("learn without a lookup or on a port out of range");

endmodule

`default_nettype wire

/* source/forward_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_ctrl (
    input  logic                    switch_clk,
    input  logic                    arst_n_i,
    desc_if.dst                     desc_i,
    lookup_if.requester             lookup_o,
    output switch_pkg::port_mask_t  push_o,
    output switch_pkg::ptr_t        push_ptr_o
);
    import switch_pkg::*;

    // stage 1, descriptor waiting for the table answer
    logic       s1_valid_q;
    port_t      s1_port_q;
    mac_t       s1_src_q;
    mac_t       s1_dst_q;
    ptr_t       s1_ptr_q;

    // stage 2, registered push
    logic       s2_valid_q;
    port_mask_t s2_mask_q;
    ptr_t       s2_ptr_q;

    fwd_e       fwd;
    port_mask_t mask;
    port_mask_t ingress_bit;

    // lookup goes out with the incoming descriptor
    assign lookup_o.read_req = desc_i.valid;
    assign lookup_o.read_mac = desc_i.dst_mac;

    // learn source against ingress once its own lookup has returned
    assign lookup_o.learn_req  = s1_valid_q;
    assign lookup_o.learn_mac  = s1_src_q;
    assign lookup_o.learn_port = s1_port_q;

    always_ff @(posedge switch_clk) begin
        if (desc_i.valid) begin
            s1_port_q <= desc_i.port;
            s1_src_q  <= desc_i.src_mac;
            s1_dst_q  <= desc_i.dst_mac;
            s1_ptr_q  <= desc_i.start_ptr;
        end
    end

    assign ingress_bit = port_mask_t'(1) << s1_port_q;

    // classify the answer
    always_comb begin
        if ((s1_dst_q == BCAST_MAC) || !lookup_o.hit) begin
            fwd = FWD_FLOOD;
        end else if (lookup_o.read_port == s1_port_q) begin
            fwd = FWD_FILTER;
        end else begin
            fwd = FWD_UNICAST;
        end
    end

    // destination mask from the decision
    always_comb begin
        case (fwd)
            FWD_UNICAST: mask = port_mask_t'(1) << lookup_o.read_port;
            FWD_FLOOD:   mask = ~ingress_bit;
            default:     mask = '0;
        endcase
    end

    always_ff @(posedge switch_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= desc_i.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge switch_clk) begin
        if (s1_valid_q) begin
            s2_mask_q <= mask;
            s2_ptr_q  <= s1_ptr_q;
        end
    end

    // one pointer shared by every pushed queue
    assign push_o     = s2_valid_q ? s2_mask_q : '0;
    assign push_ptr_o = s2_ptr_q;

    // a frame never returns to the port it came in on
    a_no_hairpin: assert property (
        @(posedge switch_clk) disable iff (!arst_n_i)
        s1_valid_q |=> !push_o[$past(s1_port_q)]
    ) else $error("push mask holds the ingress port");

endmodule

`default_nettype wire

/* source/voq.sv */
`timescale 1ns/1ps
`default_nettype none

module voq (
    input  logic                switch_clk,
    input  logic                arst_n_i,
    input  logic                push_i,
    input  switch_pkg::ptr_t    ptr_i,
    input  logic                pop_i,
    output switch_pkg::ptr_t    ptr_o,
    output logic                ptr_valid_o,
    output logic                drop_o
);
    import switch_pkg::*;

    // pointer ring, no reset on storage
    ptr_t                 mem [VOQ_DEPTH-1:0];
    logic [VOQ_IDX_W-1:0] wr_idx_q;
    logic [VOQ_IDX_W-1:0] rd_idx_q;
    logic [VOQ_CNT_W-1:0] count_q;

    logic                 do_push;
    logic                 do_pop;

    // pop only with something at the head
    assign do_pop  = pop_i && (count_q != '0);
    // full queue still takes a push when the head leaves
    assign do_push = push_i && ((32'(count_q) < VOQ_DEPTH) || do_pop);

    always_ff @(posedge switch_clk) begin
        if (do_push) begin
            mem[wr_idx_q] <= ptr_i;
        end
    end

    always_ff @(posedge switch_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            count_q  <= '0;
            drop_o   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_idx_q <= (32'(wr_idx_q) == VOQ_DEPTH - 1) ? '0 : wr_idx_q + 1'b1;
            end
            if (do_pop) begin
                rd_idx_q <= (32'(rd_idx_q) == VOQ_DEPTH - 1) ? '0 : rd_idx_q + 1'b1;
            end
            // count moves only when one side acts alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
            // one cycle pulse per discarded push
            drop_o <= push_i && !do_push;
        end
    end

    // head is a level, valid until popped
    assign ptr_o       = mem[rd_idx_q];
    assign ptr_valid_o = (count_q != '0);

    a_count_bound: assert property (
        @(posedge switch_clk) disable iff (!arst_n_i)
        32'(count_q) <= VOQ_DEPTH
    ) else $error("queue count above depth");

endmodule

`default_nettype wire

/* source/switch_core.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_core (
    input  logic                                switch_clk,
    input  logic                                arst_n_i,

    // end of frame descriptors from the ingress side
    input  logic [switch_pkg::NUM_PORTS-1:0]    frame_eof_i,
    input  switch_pkg::mac_t                    src_mac_i   [switch_pkg::NUM_PORTS-1:0],
    input  switch_pkg::mac_t                    dst_mac_i   [switch_pkg::NUM_PORTS-1:0],
    input  switch_pkg::ptr_t                    start_ptr_i [switch_pkg::NUM_PORTS-1:0],

    // egress side of each output queue
    input  logic [switch_pkg::NUM_PORTS-1:0]    voq_pop_i,
    output switch_pkg::ptr_t                    voq_ptr_o   [switch_pkg::NUM_PORTS-1:0],
    output logic [switch_pkg::NUM_PORTS-1:0]    voq_valid_o,
    output logic [switch_pkg::NUM_PORTS-1:0]    voq_drop_o
);
    import switch_pkg::*;

    // arbiter to translator
    desc_if   desc_bus ();
    // translator to address table
    lookup_if lookup_bus ();

    // translator to queues, pointer shared by all pushed ports
    port_mask_t voq_push;
    ptr_t       voq_push_ptr;

    desc_arbiter arb_inst (
        .switch_clk  (switch_clk),
        .arst_n_i    (arst_n_i),
        .frame_eof_i (frame_eof_i),
        .src_mac_i   (src_mac_i),
        .dst_mac_i   (dst_mac_i),
        .start_ptr_i (start_ptr_i),
        .desc_o      (desc_bus)
    );

    address_table addr_table (
        .switch_clk (switch_clk),
        .arst_n_i   (arst_n_i),
        .lookup_i   (lookup_bus)
    );

    forward_ctrl translator_inst (
        .switch_clk (switch_clk),
        .arst_n_i   (arst_n_i),
        .desc_i     (desc_bus),
        .lookup_o   (lookup_bus),
        .push_o     (voq_push),
        .push_ptr_o (voq_push_ptr)
    );

    // one pointer queue per output port
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_voq
        voq voq_inst (
            .switch_clk  (switch_clk),
            .arst_n_i    (arst_n_i),
            .push_i      (voq_push[g]),
            .ptr_i       (voq_push_ptr),
            .pop_i       (voq_pop_i[g]),
            .ptr_o       (voq_ptr_o[g]),
            .ptr_valid_o (voq_valid_o[g]),
            .drop_o      (voq_drop_o[g])
        );
    end

endmodule

`default_nettype wire

/* dv/switch_model.svh */
`ifndef SWITCH_MODEL_SVH
`define SWITCH_MODEL_SVH

// arbiter view, pending frames and round robin pointer
port_mask_t ref_pending;
port_t      ref_rr;
mac_t       ref_src [NUM_PORTS-1:0];
mac_t       ref_dst [NUM_PORTS-1:0];
ptr_t       ref_ptr [NUM_PORTS-1:0];

// learned addresses, direct mapped on low mac bits
mac_t       ref_tbl_mac   [TABLE_DEPTH];
port_t      ref_tbl_port  [TABLE_DEPTH];
logic       ref_tbl_valid [TABLE_DEPTH];

// decided pushes on their way, slot 2 lands in the queues next edge
logic       ref_pipe_valid [3];
port_mask_t ref_pipe_mask  [3];
ptr_t       ref_pipe_ptr   [3];

// expected queue contents
ptr_t       ref_q [NUM_PORTS][$];
int         ref_drops [NUM_PORTS];
int         n_unicast;
int         n_flood;
int         n_filter;

task automatic clear_reference();
    ref_pending = '0;
    ref_rr      = '0;
    n_unicast   = 0;
    n_flood     = 0;
    n_filter    = 0;
    for (int i = 0; i < int'(TABLE_DEPTH); i++) begin
        ref_tbl_valid[i] = 1'b0;
    end
    for (int i = 0; i < 3; i++) begin
        ref_pipe_valid[i] = 1'b0;
    end
    for (int p = 0; p < int'(NUM_PORTS); p++) begin
        ref_q[p].delete();
        ref_drops[p] = 0;
    end
endtask

// lookup first, then the forwarding rule, then learn the source
task automatic route_frame(input port_t in_port, input mac_t src, input mac_t dst,
                           output port_mask_t mask);
    logic [TABLE_IDX_W-1:0] idx;
    logic                   hit;
    idx = dst[0][TABLE_IDX_W-1:0];
    hit = ref_tbl_valid[idx] && (ref_tbl_mac[idx] == dst);
    if ((dst == BCAST_MAC) || !hit) begin
        // unknown or broadcast, all but the sender
        mask = ~(port_mask_t'(1) << in_port);
        n_flood++;
    end else if (ref_tbl_port[idx] == in_port) begin
        mask = '0;
        n_filter++;
    end else begin
        mask = port_mask_t'(1) << ref_tbl_port[idx];
        n_unicast++;
    end
    // learn evicts whatever sat at that index
    idx = src[0][TABLE_IDX_W-1:0];
    ref_tbl_mac[idx]   = src;
    ref_tbl_port[idx]  = in_port;
    ref_tbl_valid[idx] = 1'b1;
endtask

// one clock edge, using the inputs driven for the current cycle
task automatic advance_reference();
    logic        pop_ok;
    logic        push_req;
    logic        found;
    port_t       g;
    int unsigned k;
    port_mask_t  mask;
    // queues first, pop and push on the same edge both count
    for (int p = 0; p < int'(NUM_PORTS); p++) begin
        pop_ok   = voq_pop[p] && (ref_q[p].size() != 0);
        push_req = ref_pipe_valid[2] && ref_pipe_mask[2][p];
        if (pop_ok) begin
            void'(ref_q[p].pop_front());
        end
        if (push_req && (ref_q[p].size() < int'(VOQ_DEPTH))) begin
            ref_q[p].push_back(ref_pipe_ptr[2]);
        end else if (push_req) begin
            ref_drops[p]++;
        end
    end
    for (int i = 2; i > 0; i--) begin
        ref_pipe_valid[i] = ref_pipe_valid[i-1];
        ref_pipe_mask[i]  = ref_pipe_mask[i-1];
        ref_pipe_ptr[i]   = ref_pipe_ptr[i-1];
    end
    // first pending port at or after the pointer
    found = 1'b0;
    g     = ref_rr;
    for (int i = 0; i < int'(NUM_PORTS); i++) begin
        k = (32'(ref_rr) + 32'(i)) % NUM_PORTS;
        if (!found && ref_pending[k]) begin
            found = 1'b1;
            g     = port_t'(k);
        end
    end
    ref_pipe_valid[0] = found;
    if (found) begin
        route_frame(g, ref_src[g], ref_dst[g], mask);
        ref_pipe_mask[0] = mask;
        ref_pipe_ptr[0]  = ref_ptr[g];
        ref_pending[g]   = 1'b0;
        ref_rr           = port_t'((32'(g) + 1) % NUM_PORTS);
    end
    // new strobes latch after the grant used the old payload
    for (int p = 0; p < int'(NUM_PORTS); p++) begin
        if (frame_eof[p]) begin
            ref_pending[p] = 1'b1;
            ref_src[p]     = src_mac[p];
            ref_dst[p]     = dst_mac[p];
            ref_ptr[p]     = start_ptr[p];
        end
    end
endtask

function automatic logic reference_idle();
    logic idle;
    idle = (ref_pending == '0);
    for (int i = 0; i < 3; i++) begin
        if (ref_pipe_valid[i]) begin
            idle = 1'b0;
        end
    end
    for (int p = 0; p < int'(NUM_PORTS); p++) begin
        if (ref_q[p].size() != 0) begin
            idle = 1'b0;
        end
    end
    return idle;
endfunction

`endif

/* dv/switch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_tb;
    import switch_pkg::*;

    // stimulus phases in cycles
    localparam int PH_NORMAL      = 600;
    localparam int PH_BURST       = 200;
    localparam int PH_OVERFLOW    = 400;
    localparam int STIM_CYCLES    = PH_NORMAL + PH_BURST + PH_OVERFLOW;
    // drain included in the margin
    localparam int TIMEOUT_CYCLES = 20 * STIM_CYCLES;

    logic       switch_clk = 1'b0;
    logic       arst_n;
    port_mask_t frame_eof;
    mac_t       src_mac   [NUM_PORTS-1:0];
    mac_t       dst_mac   [NUM_PORTS-1:0];
    ptr_t       start_ptr [NUM_PORTS-1:0];
    port_mask_t voq_pop;
    ptr_t       voq_ptr   [NUM_PORTS-1:0];
    port_mask_t voq_valid;
    port_mask_t voq_drop;

    int seed       = 32'h9b10;
    int err_cnt    = 0;
    int check_cnt  = 0;
    int cycle_cnt  = 0;
    int stim_cycle = 0;
    int last_eof  [NUM_PORTS];
    int dut_drops [NUM_PORTS];
    int total_drops;

    `include "switch_model.svh"

    switch_core dut0 (
        .switch_clk  (switch_clk),
        .arst_n_i    (arst_n),
        .frame_eof_i (frame_eof),
        .src_mac_i   (src_mac),
        .dst_mac_i   (dst_mac),
        .start_ptr_i (start_ptr),
        .voq_pop_i   (voq_pop),
        .voq_ptr_o   (voq_ptr),
        .voq_valid_o (voq_valid),
        .voq_drop_o  (voq_drop)
    );

    always #50 switch_clk = ~switch_clk;

    // run limit
    always @(posedge switch_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // twelve addresses, i and i+6 land on the same table index
    function automatic mac_t pool_mac(input int unsigned i);
        return 48'h02a0_0000_0000 | (48'(i / 6) << 8) | 48'(i % 6);
    endfunction

    // each port mostly sends from its own three addresses
    function automatic mac_t pick_src(input int unsigned p);
        if (pick(8) == 0) begin
            return pool_mac(pick(12));
        end
        return pool_mac(3 * p + pick(3));
    endfunction

    function automatic mac_t pick_dst();
        if (pick(10) == 0) begin
            return BCAST_MAC;
        end
        return pool_mac(pick(12));
    endfunction

    task automatic check_ptr(input int port, input ptr_t got, input ptr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t: voq %0d head pointer %02h, expected %02h",
                     $time, port, got, exp);
        end
    endtask

    task automatic check_valid(input int port, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t: voq %0d valid %0b, expected %0b", $time, port, got, exp);
        end
    endtask

    task automatic check_drop(input int port, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("Fail %0t: voq %0d dropped %0d pushes, expected %0d",
                     $time, port, got, exp);
        end
    endtask

    // head of every queue against the reference
    task automatic compare_outputs();
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            check_valid(p, voq_valid[p], ref_q[p].size() != 0);
            if (voq_valid[p] && (ref_q[p].size() != 0)) begin
                check_ptr(p, voq_ptr[p], ref_q[p][0]);
            end
            if (voq_drop[p]) begin
                dut_drops[p]++;
            end
        end
    endtask

    // drive on the rising edge, compare at the falling edge, then step the model
    task automatic drive_cycle(input int unsigned eof_pct, input int unsigned pop_pct,
                               input logic burst);
        port_mask_t ready;
        port_mask_t eof_v;
        port_mask_t pop_v;
        @(posedge switch_clk);
        stim_cycle++;
        eof_v = '0;
        pop_v = '0;
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            // keep a port quiet until its last frame surely left
            ready[p] = (stim_cycle - last_eof[p]) > int'(NUM_PORTS) + 1;
            if (!burst && ready[p] && (pick(100) < eof_pct)) begin
                eof_v[p] = 1'b1;
            end
            if (pick(100) < pop_pct) begin
                pop_v[p] = 1'b1;
            end
        end
        // burst only when every port can strobe at once
        if (burst && (ready == '1)) begin
            eof_v = '1;
        end
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            if (eof_v[p]) begin
                last_eof[p]  = stim_cycle;
                src_mac[p]   <= pick_src(p);
                dst_mac[p]   <= pick_dst();
                start_ptr[p] <= ptr_t'(pick(256));
            end
        end
        frame_eof <= eof_v;
        voq_pop   <= pop_v;
        @(negedge switch_clk);
        compare_outputs();
        advance_reference();
    endtask

    initial begin
        arst_n    = 1'b0;
        frame_eof = '0;
        voq_pop   = '0;
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            src_mac[p]   = '0;
            dst_mac[p]   = '0;
            start_ptr[p] = '0;
            last_eof[p]  = -100;
            dut_drops[p] = 0;
        end
        clear_reference();
        repeat (8) @(posedge switch_clk);
        arst_n <= 1'b1;
        // out of reset, nothing queued or dropped
        @(negedge switch_clk);
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            check_valid(p, voq_valid[p], 1'b0);
            check_drop(p, int'(voq_drop[p]), 0);
        end
        advance_reference();
        repeat (4) drive_cycle(0, 0, 1'b0);
        repeat (PH_NORMAL) drive_cycle(25, 40, 1'b0);
        // all ports together, round robin order
        repeat (PH_BURST) drive_cycle(0, 60, 1'b1);
        // pops starved so queues overflow
        repeat (PH_OVERFLOW) drive_cycle(60, 4, 1'b0);
        while (!reference_idle() || (voq_valid != '0)) begin
            drive_cycle(0, 100, 1'b0);
        end
        total_drops = 0;
        for (int p = 0; p < int'(NUM_PORTS); p++) begin
            check_drop(p, dut_drops[p], ref_drops[p]);
            total_drops += ref_drops[p];
        end
        if ((n_unicast == 0) || (n_flood == 0) || (n_filter == 0)) begin
            err_cnt++;
            $display("one of unicast, flood or filter never happened");
        end
        if (total_drops == 0) begin
            err_cnt++;
            $display("no push was dropped during the overflow phase");
        end
        $display("errors %0d in %0d checks, unicast %0d flood %0d filter %0d drops %0d",
                 err_cnt, check_cnt, n_unicast, n_flood, n_filter, total_drops);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+dv
source/switch_pkg.sv
source/switch_ifs.sv
source/desc_arbiter.sv
source/address_table.sv
source/forward_ctrl.sv
source/voq.sv
source/switch_core.sv
dv/switch_tb.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= switch_tb
FILELIST ?= sources.f
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
